// File: design/harp_consts.svh
`ifndef HARP_CONSTS_SVH
`define HARP_CONSTS_SVH

// Voice count and datapath widths
`define HARP_VOICES 8
`define HARP_SAMPLE_W 32
`define HARP_PHASE_W 20
`define HARP_TIMER_W 26

// Eight voices at full level sum to 0x4000_0000 and stay positive
`define HARP_AMP_FULL 32'h0800_0000

// Amplitude lost per accepted sample while a plucked note fades
`define HARP_FADE_STEP 32'h0000_15D8

// One second at 50 MHz
`define HARP_DECAY_CYCLES 50_000_000

// Half periods in CLOCK_50 cycles, C4 up to C5
`define HARP_HALF_C 95556
`define HARP_HALF_D 85131
`define HARP_HALF_E 75843
`define HARP_HALF_F 71586
`define HARP_HALF_G 63776
`define HARP_HALF_A 56818
`define HARP_HALF_B 50619
`define HARP_HALF_C_HI 47778

`endif

// File: design/harp_pkg.sv
`include "harp_consts.svh"

package harp_pkg;

	// Release behaviour once a string is cleared
	typedef enum logic [1:0] {
		MODE_STOP        = 2'b00,
		MODE_SUSTAIN     = 2'b01,
		MODE_PLUCK       = 2'b10,
		MODE_SUSTAIN_ALT = 2'b11
	} release_mode_t;

	typedef enum logic [2:0] {
		V_IDLE,
		V_HELD,
		V_SUSTAIN,
		V_PLUCK,
		V_FADE
	} voice_state_t;

	// Signed audio word, shared by voices and mixer
	typedef logic signed [`HARP_SAMPLE_W-1:0] sample_t;

	// FSM to level logic
	typedef struct packed {
		logic sounding;
		logic fading;
		logic restart;
	} voice_ctrl_t;

	// Decay timer to FSM
	typedef struct packed {
		logic half;
		logic done;
	} timer_stat_t;

endpackage

// File: design/decay_timer.sv
`timescale 1ns/1ps
`include "harp_consts.svh"

module decay_timer #(
	parameter int unsigned decay_cycles = `HARP_DECAY_CYCLES
) (
	input  logic                  CLOCK_50,
	input  logic                  rst,
	input  logic                  run,
	output harp_pkg::timer_stat_t stat
);
	import harp_pkg::*;

	localparam int unsigned tw = `HARP_TIMER_W;
	localparam logic [tw-1:0] end_count = tw'(decay_cycles);
	localparam logic [tw-1:0] half_count = tw'(decay_cycles / 2);

	logic [tw-1:0] count;

	// Counts running cycles, holds at the end value
	always_ff @(posedge CLOCK_50)
	begin
		if (rst || !run)
		begin
			count <= '0;
		end
		else if (count != end_count)
		begin
			count <= count + 1'b1;
		end
	end

	// Half stays up from the midpoint until the count clears
	always_comb
	begin
		stat.half = (count >= half_count);
		stat.done = (count == end_count);
	end

endmodule

// File: design/tone_osc.sv
`timescale 1ns/1ps
`include "harp_consts.svh"

module tone_osc #(
	parameter int unsigned half_period = `HARP_HALF_C
) (
	input  logic CLOCK_50,
	input  logic rst,
	input  logic enable,
	output logic phase
);

	localparam int unsigned pw = `HARP_PHASE_W;
	localparam logic [pw-1:0] half_count = pw'(half_period);
	localparam logic [pw-1:0] last_count = pw'(2 * half_period - 1);

	logic [pw-1:0] count;

	// One full period is two half periods
	always_ff @(posedge CLOCK_50)
	begin
		if (rst || !enable)
		begin
			count <= '0;
		end
		else if (count == last_count)
		begin
			count <= '0;
		end
		else
		begin
			count <= count + 1'b1;
		end
	end

	// High half first, so a fresh note starts positive
	assign phase = (count < half_count);

endmodule

// File: design/release_fsm.sv
`timescale 1ns/1ps
`include "harp_consts.svh"

module release_fsm (
	input  logic                    CLOCK_50,
	input  logic                    rst,
	input  logic                    blocked,
	input  harp_pkg::release_mode_t mode,
	input  harp_pkg::timer_stat_t   stat,
	output logic                    timer_run,
	output harp_pkg::voice_ctrl_t   ctrl
);
	import harp_pkg::*;

	voice_state_t state;
	voice_state_t state_next;

	always_ff @(posedge CLOCK_50)
	begin
		if (rst)
		begin
			state <= V_IDLE;
		end
		else
		begin
			state <= state_next;
		end
	end

	always_comb
	begin
		state_next = state;
		// Blocking the string wins from any state
		if (blocked)
		begin
			state_next = V_HELD;
		end
		else
		begin
			case (state)
				V_IDLE:
					state_next = V_IDLE;
				V_HELD:
				begin
					case (mode)
						MODE_STOP:    state_next = V_IDLE;
						MODE_PLUCK:   state_next = V_PLUCK;
						default:      state_next = V_SUSTAIN;
					endcase
				end
				V_SUSTAIN:
				begin
					if (mode == MODE_STOP)
						state_next = V_IDLE;
				end
				V_PLUCK:
				begin
					// Done checked first in case the decay is very short
					if (stat.done)
						state_next = V_IDLE;
					else if (stat.half)
						state_next = V_FADE;
				end
				V_FADE:
				begin
					if (stat.done)
						state_next = V_IDLE;
				end
				default:
					state_next = V_IDLE;
			endcase
		end
	end

	// Restart follows the input so amp is full on the first held cycle
	always_comb
	begin
		ctrl.sounding = (state != V_IDLE);
		ctrl.fading   = (state == V_FADE);
		ctrl.restart  = blocked;
		timer_run     = (state == V_PLUCK) || (state == V_FADE);
	end

endmodule

// File: design/harp_voice.sv
`timescale 1ns/1ps
`include "harp_consts.svh"

module harp_voice #(
	parameter int unsigned half_period  = `HARP_HALF_C,
	parameter int unsigned decay_cycles = `HARP_DECAY_CYCLES
) (
	input  logic                    CLOCK_50,
	input  logic                    rst,
	input  logic                    blocked,
	input  harp_pkg::release_mode_t mode,
	input  logic                    sample_taken,
	output harp_pkg::sample_t       level,
	output logic                    sounding
);
	import harp_pkg::*;

	localparam sample_t amp_full  = `HARP_AMP_FULL;
	localparam sample_t fade_step = `HARP_FADE_STEP;

	timer_stat_t stat;
	voice_ctrl_t ctrl;
	logic        timer_run;
	logic        phase;
	sample_t     amp;

	release_fsm u_fsm (
		.CLOCK_50 (CLOCK_50),
		.rst      (rst),
		.blocked  (blocked),
		.mode     (mode),
		.stat     (stat),
		.timer_run(timer_run),
		.ctrl     (ctrl)
	);

	decay_timer #(
		.decay_cycles(decay_cycles)
	) u_timer (
		.CLOCK_50(CLOCK_50),
		.rst     (rst),
		.run     (timer_run),
		.stat    (stat)
	);

	tone_osc #(
		.half_period(half_period)
	) u_osc (
		.CLOCK_50(CLOCK_50),
		.rst     (rst),
		.enable  (ctrl.sounding),
		.phase   (phase)
	);

	// Fade only steps when the codec really took a sample
	always_ff @(posedge CLOCK_50)
	begin
		if (ctrl.restart)
			amp <= amp_full;
		else if (ctrl.fading && sample_taken)
			amp <= (amp > fade_step) ? amp - fade_step : '0;
	end

	always_comb
	begin
		if (!ctrl.sounding)
			level = '0;
		else if (phase)
			level = amp;
		else
			level = -amp;
	end

	assign sounding = ctrl.sounding;

endmodule

// File: design/voice_mixer.sv
`timescale 1ns/1ps
`include "harp_consts.svh"

module voice_mixer (
	input  logic                     CLOCK_50,
	input  logic                     rst,
	input  harp_pkg::sample_t        levels [`HARP_VOICES],
	input  logic [`HARP_VOICES-1:0]  sounding,
	input  logic                     sample_ready,
	output harp_pkg::sample_t        sample_data,
	output logic                     sample_valid,
	output logic                     sample_taken
);
	import harp_pkg::*;

	sample_t sum;
	logic    hold;

	// Amplitude limit keeps this sum inside the signed range
	always_comb
	begin
		sum = '0;
		for (int v = 0; v < `HARP_VOICES; v++)
		begin
			sum = sum + levels[v];
		end
	end

	// Offered sample must not move until it is taken
	assign hold = sample_valid && !sample_ready;

	always_ff @(posedge CLOCK_50)
	begin
		if (rst)
		begin
			sample_data  <= '0;
			sample_valid <= 1'b0;
		end
		else if (!hold)
		begin
			sample_data  <= sum;
			sample_valid <= |sounding;
		end
	end

	// Transfer pulse, fed back to every voice for the fade
	assign sample_taken = sample_valid && sample_ready;

endmodule

// File: design/harp_top.sv
`timescale 1ns/1ps
`include "harp_consts.svh"

module harp_top #(
	parameter int unsigned decay_cycles = `HARP_DECAY_CYCLES
) (
	input  logic                    CLOCK_50,
	input  logic                    rst,
	input  logic [`HARP_VOICES-1:0] strings,
	input  harp_pkg::release_mode_t mode,
	input  logic                    sample_ready,
	output harp_pkg::sample_t       sample_data,
	output logic                    sample_valid
);
	import harp_pkg::*;

	// String i maps to entry i, low C first
	localparam int unsigned half_table [`HARP_VOICES] = '{
		`HARP_HALF_C, `HARP_HALF_D, `HARP_HALF_E, `HARP_HALF_F,
		`HARP_HALF_G, `HARP_HALF_A, `HARP_HALF_B, `HARP_HALF_C_HI
	};

	sample_t                 levels [`HARP_VOICES];
	logic [`HARP_VOICES-1:0] sounding;
	logic                    sample_taken;

	for (genvar i = 0; i < `HARP_VOICES; i++)
	begin : g_voice
		harp_voice #(
			.half_period (half_table[i]),
			.decay_cycles(decay_cycles)
		) u_voice (
			.CLOCK_50    (CLOCK_50),
			.rst         (rst),
			.blocked     (strings[i]),
			.mode        (mode),
			.sample_taken(sample_taken),
			.level       (levels[i]),
			.sounding    (sounding[i])
		);
	end

	voice_mixer u_mixer (
		.CLOCK_50    (CLOCK_50),
		.rst         (rst),
		.levels      (levels),
		.sounding    (sounding),
		.sample_ready(sample_ready),
		.sample_data (sample_data),
		.sample_valid(sample_valid),
		.sample_taken(sample_taken)
	);

endmodule

// File: dv/harp_properties.sv
`timescale 1ns/1ps

module harp_properties (
	input logic              CLOCK_50,
	input logic              rst,
	input logic              sample_ready,
	input harp_pkg::sample_t sample_data,
	input logic              sample_valid,
	input logic              sample_taken
);

	// Nothing is offered in the cycle after reset
	property valid_low_after_reset;
		@(posedge CLOCK_50) rst |=> !sample_valid;
	endproperty

	// A stalled sample stays offered and unchanged
	property held_while_stalled;
		@(posedge CLOCK_50) disable iff (rst)
		(sample_valid && !sample_ready) |=> (sample_valid && $stable(sample_data));
	endproperty

	property taken_is_handshake;
		@(posedge CLOCK_50) sample_taken == (sample_valid && sample_ready);
	endproperty

	a_reset_valid: assert property (valid_low_after_reset)
		else $error("sample_valid high right after reset");
	a_stall_hold: assert property (held_while_stalled)
		else $error("Output sample changed while stalled");
	a_taken: assert property (taken_is_handshake)
		else $error("sample_taken differs from valid and ready");

endmodule

bind voice_mixer harp_properties u_props (
	.CLOCK_50    (CLOCK_50),
	.rst         (rst),
	.sample_ready(sample_ready),
	.sample_data (sample_data),
	.sample_valid(sample_valid),
	.sample_taken(sample_taken)
);

// File: dv/tb_harp.sv
`timescale 1ns/1ps
`include "harp_consts.svh"

module tb_harp;
	import harp_pkg::*;

	localparam int unsigned decay = 40;
	localparam int unsigned half_len [`HARP_VOICES] = '{
		`HARP_HALF_C, `HARP_HALF_D, `HARP_HALF_E, `HARP_HALF_F,
		`HARP_HALF_G, `HARP_HALF_A, `HARP_HALF_B, `HARP_HALF_C_HI
	};
	localparam sample_t amp_full  = `HARP_AMP_FULL;
	localparam sample_t fade_step = `HARP_FADE_STEP;

	logic                    CLOCK_50;
	logic                    rst;
	logic [`HARP_VOICES-1:0] strings;
	release_mode_t           mode;
	logic                    sample_ready;
	sample_t                 sample_data;
	logic                    sample_valid;

	logic ready_random;
	logic timed_out;
	int   errors;
	int   checks;
	int   tests;
	int   failed_tests;

	// Expected voice and output registers
	voice_state_t m_state [`HARP_VOICES];
	int unsigned  m_osc [`HARP_VOICES];
	int unsigned  m_tmr [`HARP_VOICES];
	sample_t      m_amp [`HARP_VOICES];
	sample_t      m_data;
	logic         m_valid;

	harp_top #(
		.decay_cycles(decay)
	) UUT (
		.CLOCK_50    (CLOCK_50),
		.rst         (rst),
		.strings     (strings),
		.mode        (mode),
		.sample_ready(sample_ready),
		.sample_data (sample_data),
		.sample_valid(sample_valid)
	);

	initial
	begin
		CLOCK_50 = 1'b0;
		forever #50 CLOCK_50 = ~CLOCK_50;
	end

	// Ready pattern, chosen at the edge and driven just after it
	initial
	begin
		logic ready_next;
		sample_ready = 1'b1;
		forever
		begin
			@(posedge CLOCK_50);
			ready_next = ready_random ? ($urandom % 4 != 0) : 1'b1;
			#5;
			sample_ready = ready_next;
		end
	end

	// Sum of plus or minus amp over the sounding voices
	function automatic sample_t expected_sum(input logic [`HARP_VOICES-1:0] active,
			input logic [`HARP_VOICES-1:0] phase_hi, input sample_t amps [`HARP_VOICES]);
		sample_t total;
		total = '0;
		for (int v = 0; v < `HARP_VOICES; v++)
		begin
			if (active[v])
				total = total + (phase_hi[v] ? amps[v] : -amps[v]);
		end
		return total;
	endfunction

	function automatic voice_state_t next_state(input voice_state_t cur, input logic blocked,
			input release_mode_t md, input logic half, input logic done);
		if (blocked)
			return V_HELD;
		case (cur)
			V_HELD:
			begin
				if (md == MODE_STOP)
					return V_IDLE;
				return (md == MODE_PLUCK) ? V_PLUCK : V_SUSTAIN;
			end
			V_SUSTAIN:
				return (md == MODE_STOP) ? V_IDLE : V_SUSTAIN;
			V_PLUCK:
				return half ? V_FADE : V_PLUCK;
			V_FADE:
				return done ? V_IDLE : V_FADE;
			default:
				return V_IDLE;
		endcase
	endfunction

	// Advance the model on every edge
	always @(posedge CLOCK_50)
	begin
		logic [`HARP_VOICES-1:0] active;
		logic [`HARP_VOICES-1:0] phase_hi;
		logic                    taken;
		logic                    half;
		logic                    done;
		for (int v = 0; v < `HARP_VOICES; v++)
		begin
			active[v]   = (m_state[v] != V_IDLE);
			phase_hi[v] = (m_osc[v] < half_len[v]);
		end
		taken = m_valid && sample_ready;
		if (rst)
		begin
			m_data  = '0;
			m_valid = 1'b0;
		end
		else if (!m_valid || sample_ready)
		begin
			m_data  = expected_sum(active, phase_hi, m_amp);
			m_valid = |active;
		end
		for (int v = 0; v < `HARP_VOICES; v++)
		begin
			half = (m_tmr[v] >= decay / 2);
			done = (m_tmr[v] == decay);
			if (rst)
				m_amp[v] = '0;
			else if (strings[v])
				m_amp[v] = amp_full;
			else if (m_state[v] == V_FADE && taken)
				m_amp[v] = (m_amp[v] > fade_step) ? m_amp[v] - fade_step : '0;
			if (rst || !active[v] || m_osc[v] == 2 * half_len[v] - 1)
				m_osc[v] = 0;
			else
				m_osc[v]++;
			if (rst || !(m_state[v] == V_PLUCK || m_state[v] == V_FADE))
				m_tmr[v] = 0;
			else if (!done)
				m_tmr[v]++;
			m_state[v] = rst ? V_IDLE : next_state(m_state[v], strings[v], mode, half, done);
		end
	end

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] got);
		checks++;
		if (expected !== got)
		begin
			$display("Mismatch %s expected %h got %h", name, expected, got);
			errors++;
		end
	endtask

	// Outputs are settled at the falling edge
	always @(negedge CLOCK_50)
	begin
		if (!rst)
		begin
			check_value("sample_valid", 32'(m_valid), 32'(sample_valid));
			if (sample_valid && sample_ready)
				check_value("sample_data", m_data, sample_data);
		end
	end

	task automatic step(input int n);
		repeat (n) @(posedge CLOCK_50);
		#5;
	endtask

	task automatic note_timeout(input string what, input int limit);
		$display("Timeout: %s did not happen within %0d cycles", what, limit);
		timed_out = 1'b1;
	endtask

	task automatic wait_valid(input logic level, input int limit, input string what);
		int cycles;
		cycles = 0;
		while (sample_valid !== level && !timed_out)
		begin
			step(1);
			cycles++;
			if (cycles > limit)
				note_timeout(what, limit);
		end
	endtask

	task automatic finish_test(input string name, input int err_before);
		tests++;
		if (errors != err_before || timed_out)
		begin
			failed_tests++;
			$display("Test %0d %s: FAILED", tests, name);
		end
		else
			$display("Test %0d %s: ok", tests, name);
	endtask

	initial
	begin
		int      err_before;
		int      cycles;
		int      run_len;
		int      flips;
		int      drops;
		int      full_len;
		logic    last_sign;
		sample_t mag;
		sample_t prev_mag;
		void'($urandom(84014));
		rst = 1'b1;
		strings = '0;
		mode = MODE_STOP;
		ready_random = 1'b0;
		timed_out = 1'b0;
		errors = 0;
		checks = 0;
		tests = 0;
		failed_tests = 0;
		step(8);
		rst = 1'b0;

		err_before = errors;
		for (int i = 0; i < 20; i++)
		begin
			step(1);
			check_value("sample_valid", 32'd0, 32'(sample_valid));
			check_value("sample_data", 32'd0, sample_data);
		end
		finish_test("idle after reset", err_before);

		// High C, sign must flip every half period
		err_before = errors;
		mode = MODE_SUSTAIN;
		strings = 8'h80;
		wait_valid(1'b1, 4, "first sample of a held string");
		last_sign = 1'b0;
		run_len = 1;
		flips = 0;
		cycles = 0;
		while (flips < 2 && !timed_out)
		begin
			step(1);
			mag = sample_data[31] ? -sample_data : sample_data;
			check_value("sample_magnitude", amp_full, mag);
			if (sample_data[31] == last_sign)
				run_len++;
			else
			begin
				check_value("half_period", half_len[7], run_len);
				flips++;
				run_len = 1;
				last_sign = sample_data[31];
			end
			cycles++;
			if (cycles > 3 * int'(half_len[7]))
				note_timeout("two sign changes", 3 * int'(half_len[7]));
		end
		mode = MODE_STOP;
		strings = '0;
		wait_valid(1'b0, 3, "silence after the single note");
		finish_test("single note", err_before);

		err_before = errors;
		ready_random = 1'b1;
		mode = MODE_SUSTAIN;
		for (int r = 0; r < 12; r++)
		begin
			strings = 8'($urandom);
			step(150);
		end
		mode = MODE_STOP;
		strings = '0;
		wait_valid(1'b0, 50, "silence after random chords");
		ready_random = 1'b0;
		finish_test("random chords", err_before);

		err_before = errors;
		strings = 8'hFF;
		step(100);
		strings = '0;
		wait_valid(1'b0, 3, "silence after a stop release");
		for (int i = 0; i < 20; i++)
		begin
			step(1);
			check_value("sample_valid", 32'd0, 32'(sample_valid));
		end
		finish_test("stop release", err_before);

		err_before = errors;
		mode = MODE_PLUCK;
		strings = 8'h01;
		step(50);
		strings = '0;
		cycles = 0;
		full_len = 0;
		drops = 0;
		prev_mag = amp_full;
		while (sample_valid && !timed_out)
		begin
			mag = sample_data[31] ? -sample_data : sample_data;
			if (mag == amp_full)
				full_len++;
			else
			begin
				check_value("fade_step", fade_step, prev_mag - mag);
				drops++;
			end
			prev_mag = mag;
			step(1);
			cycles++;
			if (cycles > int'(decay) + 3)
				note_timeout("silence after a pluck", int'(decay) + 3);
		end
		if (full_len < int'(decay / 2) || drops == 0)
		begin
			$display("Pluck note did not hold full level to the half point and then fade");
			errors++;
		end
		if (cycles < int'(decay))
		begin
			$display("Pluck note went silent after %0d cycles, before the decay time", cycles);
			errors++;
		end
		finish_test("pluck release", err_before);

		err_before = errors;
		mode = MODE_SUSTAIN;
		strings = 8'h08;
		step(20);
		strings = '0;
		for (int i = 0; i < 200; i++)
		begin
			step(1);
			mag = sample_data[31] ? -sample_data : sample_data;
			check_value("sample_valid", 32'd1, 32'(sample_valid));
			check_value("sample_magnitude", amp_full, mag);
		end
		mode = MODE_STOP;
		wait_valid(1'b0, 3, "silence after sustain is stopped");
		finish_test("sustain release", err_before);

		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			tests, failed_tests, checks, errors);
		if (errors == 0 && !timed_out)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: build.f
+incdir+design
design/harp_pkg.sv
design/decay_timer.sv
design/tone_osc.sv
design/release_fsm.sv
design/harp_voice.sv
design/voice_mixer.sv
design/harp_top.sv
dv/harp_properties.sv
dv/tb_harp.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the harp testbench with Verilator
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f build.f --top-module tb_harp -o tb_harp
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_harp > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "Simulator exited with status $status"
	exit 1
fi

# The log decides the result
if grep -q "^Simulation passed$" "$log"; then
	exit 0
fi
exit 1
